// ==== all.f ====
sys_pkg.sv
free_list.sv
rename_map.sv
rob.sv
arch_map.sv
ooo_core_top.sv
tb_core.sv

// ==== arch_map.sv ====
//////////////////////////////
// committed architectural map
//////////////////////////////
`timescale 1ns/1ps

module arch_map #(
    parameter int n = 2
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  sys_pkg::rob_packet [n-1:0]                    retiring_data,
    input  logic [$clog2(n+1)-1:0]                        num_retired,
    output sys_pkg::phys_reg_idx [sys_pkg::arch_regs-1:0] arch_table
);
    import sys_pkg::*;

    phys_reg_idx [arch_regs-1:0] map_table;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int r = 0; r < arch_regs; r++) begin
                map_table[r] <= phys_reg_idx'(r);
            end
        end else begin
            // slot order, youngest retiring write wins
            for (int i = 0; i < n; i++) begin
                if (i < int'(num_retired) && retiring_data[i].dest_reg_idx != '0) begin
                    map_table[retiring_data[i].dest_reg_idx] <= retiring_data[i].t;
                end
            end
        end
    end

    assign arch_table = map_table;

endmodule

// ==== free_list.sv ====
//////////////////////////////
// fifo of free physical tags
//////////////////////////////
`timescale 1ns/1ps

module free_list #(
    parameter int n = 2
) (
    input  logic                          clock,
    input  logic                          reset,
    input  logic [$clog2(n+1)-1:0]        num_accept,
    output sys_pkg::phys_reg_idx [n-1:0]  alloc_tags,
    output logic [$clog2(n+1)-1:0]        free_count,
    input  sys_pkg::rob_packet [n-1:0]    retiring_data,
    input  logic [$clog2(n+1)-1:0]        num_retired
);
    import sys_pkg::*;

    localparam int lg = $clog2(free_regs);
    localparam int cw = $clog2(n+1);

    phys_reg_idx [free_regs-1:0] tags;
    logic [lg-1:0] head;
    logic [lg-1:0] tail;
    // number of tags currently held
    logic [lg:0]   count;

    // next n tags from head of which num_accept get used
    always_comb begin
        for (int j = 0; j < n; j++) begin
            alloc_tags[j] = tags[head + lg'(j)];
        end
    end

    assign free_count = (count > (lg+1)'(n)) ? cw'(n) : cw'(count);

    always_ff @(posedge clock) begin
        if (reset) begin
            // tags above the identity mapping, in order
            for (int i = 0; i < free_regs; i++) begin
                tags[i] <= phys_reg_idx'(arch_regs + i);
            end
            head  <= '0;
            tail  <= '0;
            count <= (lg+1)'(free_regs);
        end else begin
            // retired t_old back in slot order
            for (int i = 0; i < n; i++) begin
                if (i < int'(num_retired)) begin
                    tags[tail + lg'(i)] <= retiring_data[i].t_old;
                end
            end
            head  <= head + lg'(num_accept);
            tail  <= tail + lg'(num_retired);
            count <= count - (lg+1)'(num_accept) + (lg+1)'(num_retired);
        end
    end

endmodule

// ==== ooo_core_top.sv ====
//////////////////////////////
// rename, free list, rob and arch map
//////////////////////////////
`timescale 1ns/1ps

module ooo_core_top #(
    parameter int n         = 2,
    parameter int rob_depth = 16
) (
    input  logic                                          clock,
    input  logic                                          reset,
    input  sys_pkg::decoded_packet [n-1:0]                dispatch_data,
    input  logic [$clog2(n+1)-1:0]                        dispatch_count,
    input  sys_pkg::complete_packet [n-1:0]               cdb,
    input  logic                                          dm_stalled,
    output logic [$clog2(n+1)-1:0]                        num_accept,
    output sys_pkg::rob_packet [n-1:0]                    retiring_data,
    output logic [$clog2(n+1)-1:0]                        num_retired,
    output logic                                          start_store,
    output sys_pkg::phys_reg_idx [sys_pkg::arch_regs-1:0] arch_table
);
    import sys_pkg::*;

    // tags from free list head, previous mappings from rename
    phys_reg_idx [n-1:0]     alloc_tags;
    phys_reg_idx [n-1:0]     t_old;
    logic [$clog2(n+1)-1:0]  free_count;

    free_list #(.n(n)) u_free_list (
        .clock(clock), .reset(reset),
        .num_accept(num_accept), .alloc_tags(alloc_tags), .free_count(free_count),
        .retiring_data(retiring_data), .num_retired(num_retired)
    );

    rename_map #(.n(n)) u_rename_map (
        .clock(clock), .reset(reset),
        .dispatch_data(dispatch_data), .num_accept(num_accept),
        .alloc_tags(alloc_tags), .t_old(t_old)
    );

    // num_accept is resolved inside the rob
    rob #(.n(n), .rob_depth(rob_depth)) u_rob (
        .clock(clock), .reset(reset),
        .dispatch_data(dispatch_data), .dispatch_count(dispatch_count),
        .t(alloc_tags), .t_old(t_old), .free_count(free_count),
        .cdb(cdb), .dm_stalled(dm_stalled), .num_accept(num_accept),
        .retiring_data(retiring_data), .num_retired(num_retired),
        .start_store(start_store)
    );

    arch_map #(.n(n)) u_arch_map (
        .clock(clock), .reset(reset),
        .retiring_data(retiring_data), .num_retired(num_retired),
        .arch_table(arch_table)
    );

endmodule

// ==== rename_map.sv ====
//////////////////////////////
// speculative rename map table
//////////////////////////////
`timescale 1ns/1ps

module rename_map #(
    parameter int n = 2
) (
    input  logic                           clock,
    input  logic                           reset,
    input  sys_pkg::decoded_packet [n-1:0] dispatch_data,
    input  logic [$clog2(n+1)-1:0]         num_accept,
    input  sys_pkg::phys_reg_idx [n-1:0]   alloc_tags,
    output sys_pkg::phys_reg_idx [n-1:0]   t_old
);
    import sys_pkg::*;

    phys_reg_idx [arch_regs-1:0] map_table;

    // previous mapping per slot
    always_comb begin
        for (int j = 0; j < n; j++) begin
            t_old[j] = map_table[dispatch_data[j].dest_reg_idx];
            // youngest earlier slot with same dest wins
            // an accepted slot implies all earlier ones are accepted
            for (int i = 0; i < j; i++) begin
                if (dispatch_data[i].dest_reg_idx == dispatch_data[j].dest_reg_idx) begin
                    t_old[j] = alloc_tags[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity mapping
            for (int r = 0; r < arch_regs; r++) begin
                map_table[r] <= phys_reg_idx'(r);
            end
        end else begin
            // later slot overwrites earlier one
            for (int j = 0; j < n; j++) begin
                // r0 stays on its tag
                if (j < int'(num_accept) && dispatch_data[j].dest_reg_idx != '0) begin
                    map_table[dispatch_data[j].dest_reg_idx] <= alloc_tags[j];
                end
            end
        end
    end

endmodule

// ==== rob.sv ====
//////////////////////////////
// n-way circular reorder buffer
//////////////////////////////
`timescale 1ns/1ps

module rob #(
    parameter int n         = 2,
    parameter int rob_depth = 16
) (
    input  logic                             clock,
    input  logic                             reset,
    input  sys_pkg::decoded_packet [n-1:0]   dispatch_data,
    input  logic [$clog2(n+1)-1:0]           dispatch_count,
    input  sys_pkg::phys_reg_idx [n-1:0]     t,
    input  sys_pkg::phys_reg_idx [n-1:0]     t_old,
    input  logic [$clog2(n+1)-1:0]           free_count,
    input  sys_pkg::complete_packet [n-1:0]  cdb,
    input  logic                             dm_stalled,
    output logic [$clog2(n+1)-1:0]           num_accept,
    output sys_pkg::rob_packet [n-1:0]       retiring_data,
    output logic [$clog2(n+1)-1:0]           num_retired,
    output logic                             start_store
);
    import sys_pkg::*;

    localparam int lg = $clog2(rob_depth);
    localparam int cw = $clog2(n+1);

    // head is the oldest entry, tail one past the youngest
    logic [lg-1:0] head;
    logic [lg-1:0] tail;
    logic [lg:0]   count;
    rob_packet [rob_depth-1:0] entries;
    rob_packet [rob_depth-1:0] next_entries;

    logic [lg+1:0] room;
    logic [cw-1:0] open_entries;
    logic [cw-1:0] limit;
    logic          stop;
    logic          store_done;
    logic [lg-1:0] ridx;
    logic [lg-1:0] widx;
    logic [lg-1:0] off;

    // retirement walk from head in age order
    always_comb begin
        retiring_data = '0;
        num_retired   = '0;
        stop          = 1'b0;
        store_done    = 1'b0;
        ridx          = head;
        for (int i = 0; i < n; i++) begin
            ridx = head + lg'(i);
            if (!stop) begin
                if (i >= int'(count) || !entries[ridx].complete) begin
                    // empty or still waiting on the cdb
                    stop = 1'b1;
                end else if (entries[ridx].wr_mem && (dm_stalled || store_done)) begin
                    // one store per cycle, none while memory stalls
                    stop = 1'b1;
                end else if (entries[ridx].halt && (dm_stalled || store_done)) begin
                    stop = 1'b1;
                end else begin
                    retiring_data[i] = entries[ridx];
                    num_retired      = num_retired + 1'b1;
                    if (entries[ridx].wr_mem) begin
                        store_done = 1'b1;
                    end
                end
            end
        end
    end

    assign start_store = store_done;

    // free slots after this cycle's retirement capped at n
    assign room = (lg+2)'(rob_depth) - (lg+2)'(count) + (lg+2)'(num_retired);
    assign open_entries = (room > (lg+2)'(n)) ? cw'(n) : cw'(room);

    // min of offered, rob room and free tags
    assign limit      = (open_entries < free_count) ? open_entries : free_count;
    assign num_accept = (dispatch_count < limit) ? dispatch_count : limit;

    always_comb begin
        next_entries = entries;
        off          = '0;
        widx         = tail;
        // cdb match, only against occupied entries
        for (int k = 0; k < rob_depth; k++) begin
            off = lg'(k) - head;
            if ((lg+1)'(off) < count) begin
                for (int j = 0; j < n; j++) begin
                    if (cdb[j].valid && cdb[j].t == entries[k].t) begin
                        next_entries[k].complete = 1'b1;
                        next_entries[k].data     = cdb[j].data;
                    end
                end
            end
        end
        // accepted packets go in at the tail starting with slot 0
        // may reuse a slot freed by retirement this cycle
        for (int j = 0; j < n; j++) begin
            widx = tail + lg'(j);
            if (j < int'(num_accept)) begin
                next_entries[widx].pc           = dispatch_data[j].pc;
                next_entries[widx].dest_reg_idx = dispatch_data[j].dest_reg_idx;
                next_entries[widx].halt         = dispatch_data[j].halt;
                next_entries[widx].wr_mem       = dispatch_data[j].wr_mem;
                next_entries[widx].t            = t[j];
                // r0 never remaps, so its own tag goes back on retire
                if (dispatch_data[j].dest_reg_idx == '0) begin
                    next_entries[widx].t_old = t[j];
                end else begin
                    next_entries[widx].t_old = t_old[j];
                end
                next_entries[widx].data     = '0;
                next_entries[widx].complete = 1'b0;
            end
        end
    end

    // entry payload array
    always_ff @(posedge clock) begin
        entries <= next_entries;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            head  <= head + lg'(num_retired);
            tail  <= tail + lg'(num_accept);
            count <= count - (lg+1)'(num_retired) + (lg+1)'(num_accept);
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run tb_core with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_core -o tb_core
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/tb_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    exit 1
fi

echo "$out" | grep -qx ">>> PASS" || exit 1
exit 0

// ==== sys_pkg.sv ====
//////////////////////////////
// register sizes, index types and the
// dispatch, completion and rob entry structs
//////////////////////////////
package sys_pkg;

    // register file sizes
    localparam int arch_regs = 32;
    localparam int phys_regs = 64;
    // tags not held by the initial identity mapping
    localparam int free_regs = phys_regs - arch_regs;

    typedef logic [$clog2(arch_regs)-1:0] arch_reg_idx;
    typedef logic [$clog2(phys_regs)-1:0] phys_reg_idx;
    typedef logic [31:0] data_word;

    // one decoded instruction offered for dispatch
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_idx dest_reg_idx;
        logic        halt;
        // store, retires under the data memory rules
        logic        wr_mem;
    } decoded_packet;

    // one cdb lane
    typedef struct packed {
        logic        valid;
        phys_reg_idx t;
        data_word    data;
    } complete_packet;

    // one rob entry, also the retiring view
    typedef struct packed {
        logic [31:0] pc;
        arch_reg_idx dest_reg_idx;
        // new tag for dest
        phys_reg_idx t;
        // previous tag, freed on retirement
        phys_reg_idx t_old;
        data_word    data;
        logic        halt;
        logic        wr_mem;
        logic        complete;
    } rob_packet;

endpackage

// ==== tb_core.sv ====
//////////////////////////////
// random dispatch and cdb driver with a
// reference model of renaming and retirement
//////////////////////////////
`timescale 1ns/1ps

module tb_core;
    import sys_pkg::*;

    localparam int n         = 2;
    localparam int rob_depth = 16;
    localparam int cw        = $clog2(n+1);

    typedef logic [127:0] wide_t;

    logic                        clock;
    logic                        reset;
    decoded_packet [n-1:0]       dispatch_data;
    logic [cw-1:0]               dispatch_count;
    complete_packet [n-1:0]      cdb;
    logic                        dm_stalled;
    logic [cw-1:0]               num_accept;
    rob_packet [n-1:0]           retiring_data;
    logic [cw-1:0]               num_retired;
    logic                        start_store;
    phys_reg_idx [arch_regs-1:0] arch_table;

    // model state
    int            free_q[$];
    int            ren_table[arch_regs];
    int            arch_model[arch_regs];
    rob_packet     rob_q[$];
    // offered but not yet accepted, oldest first
    decoded_packet pending[$];
    int            pc_next;
    int            accepted_total;
    int            target;
    int            guard;

    ooo_core_top #(.n(n), .rob_depth(rob_depth)) dut_i (
        .clock(clock), .reset(reset),
        .dispatch_data(dispatch_data), .dispatch_count(dispatch_count),
        .cdb(cdb), .dm_stalled(dm_stalled), .num_accept(num_accept),
        .retiring_data(retiring_data), .num_retired(num_retired),
        .start_store(start_store), .arch_table(arch_table)
    );

    always #2 clock = ~clock;

    task automatic check_value(input string name, input wide_t got, input wide_t exp);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("timeout at t=%0t: %s", $time, what);
        $display(">>> FAIL");
        $fatal(1, "timeout");
    endtask

    // drives at negedge and checks mid-cycle before advancing the model
    task automatic step(input bit do_dispatch, input bit do_stall, input bit do_complete);
        rob_packet     exp_ret[n];
        rob_packet     e;
        decoded_packet p;
        int            cand[$];
        int            ret;
        int            dcount;
        int            acc;
        int            room;
        int            k;
        int            d;
        bit            stop;
        bit            store_done;
        bit            stall;
        @(negedge clock);
        stall = do_stall && ($urandom_range(0, 3) == 0);
        // retirement walk over the model rob
        ret        = 0;
        stop       = 1'b0;
        store_done = 1'b0;
        for (int i = 0; i < n; i++) begin
            exp_ret[i] = '0;
            if (!stop && i >= rob_q.size()) begin
                stop = 1'b1;
            end else if (!stop) begin
                if (!rob_q[i].complete) begin
                    stop = 1'b1;
                end else if ((rob_q[i].wr_mem || rob_q[i].halt) && (stall || store_done)) begin
                    stop = 1'b1;
                end else begin
                    exp_ret[i] = rob_q[i];
                    ret++;
                    store_done = store_done | rob_q[i].wr_mem;
                end
            end
        end
        // new packets top up the group behind re-offered ones
        dcount = 0;
        if (do_dispatch) begin
            dcount = $urandom_range(0, n);
            while (pending.size() < dcount) begin
                // small dest pool half the time, so r0 and repeats show up
                if ($urandom_range(0, 1) == 0) begin
                    d = $urandom_range(0, 3);
                end else begin
                    d = $urandom_range(0, 31);
                end
                p.pc           = 32'(pc_next);
                p.dest_reg_idx = arch_reg_idx'(d);
                p.halt         = ($urandom_range(0, 49) == 0);
                p.wr_mem       = ($urandom_range(0, 4) == 0);
                pc_next        = pc_next + 4;
                pending.push_back(p);
            end
        end
        for (int j = 0; j < n; j++) begin
            dispatch_data[j] = (j < dcount) ? pending[j] : '0;
        end
        dispatch_count = cw'(dcount);
        dm_stalled     = stall;
        // cdb lanes pick distinct incomplete entries
        for (int i = 0; i < rob_q.size(); i++) begin
            if (!rob_q[i].complete) begin
                cand.push_back(i);
            end
        end
        for (int j = 0; j < n; j++) begin
            cdb[j] = '0;
            if (do_complete && cand.size() > 0 && $urandom_range(0, 3) != 0) begin
                k           = $urandom_range(0, cand.size() - 1);
                e           = rob_q[cand[k]];
                e.complete  = 1'b1;
                e.data      = $urandom();
                rob_q[cand[k]] = e;
                cdb[j].valid = 1'b1;
                cdb[j].t     = e.t;
                cdb[j].data  = e.data;
                cand.delete(k);
            end
        end
        #1;
        // min of offered, rob room after retirement, free tags
        room = rob_depth - rob_q.size() + ret;
        acc  = dcount;
        if (room < acc) begin
            acc = room;
        end
        if (free_q.size() < acc) begin
            acc = free_q.size();
        end
        check_value("num_accept", wide_t'(num_accept), wide_t'(acc));
        check_value("num_retired", wide_t'(num_retired), wide_t'(ret));
        check_value("start_store", wide_t'(start_store), wide_t'(store_done));
        for (int j = 0; j < n; j++) begin
            check_value($sformatf("retiring_data[%0d]", j), wide_t'(retiring_data[j]),
                        wide_t'(exp_ret[j]));
        end
        for (int r = 0; r < arch_regs; r++) begin
            check_value($sformatf("arch_table[%0d]", r), wide_t'(arch_table[r]),
                        wide_t'(arch_model[r]));
        end
        // commit to arch map and return t_old to the free list
        for (int i = 0; i < ret; i++) begin
            e = rob_q.pop_front();
            if (e.dest_reg_idx != '0) begin
                arch_model[e.dest_reg_idx] = int'(e.t);
            end
            free_q.push_back(int'(e.t_old));
        end
        // rename in slot order, so later slots see earlier ones
        for (int j = 0; j < acc; j++) begin
            p              = pending.pop_front();
            e              = '0;
            e.pc           = p.pc;
            e.dest_reg_idx = p.dest_reg_idx;
            e.halt         = p.halt;
            e.wr_mem       = p.wr_mem;
            e.t            = phys_reg_idx'(free_q.pop_front());
            if (p.dest_reg_idx == '0) begin
                e.t_old = e.t;
            end else begin
                e.t_old = phys_reg_idx'(ren_table[p.dest_reg_idx]);
                ren_table[p.dest_reg_idx] = int'(e.t);
            end
            rob_q.push_back(e);
            accepted_total++;
        end
    endtask

    task automatic drain();
        int count;
        count = 0;
        while (rob_q.size() > 0) begin
            step(1'b0, 1'b0, 1'b1);
            count++;
            if (count > 500) begin
                timeout_fail("rob did not drain");
            end
        end
    endtask

    initial begin
        void'($urandom(17));
        clock          = 1'b0;
        reset          = 1'b1;
        dispatch_data  = '0;
        dispatch_count = '0;
        cdb            = '0;
        dm_stalled     = 1'b0;
        pc_next        = 32'h1000;
        accepted_total = 0;
        for (int i = 0; i < free_regs; i++) begin
            free_q.push_back(arch_regs + i);
        end
        for (int r = 0; r < arch_regs; r++) begin
            ren_table[r]  = r;
            arch_model[r] = r;
        end
        repeat (4) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        for (int c = 0; c < 3000; c++) begin
            // stretches without completions fill the rob
            step(1'b1, 1'b1, (c % 150) >= 30);
        end
        drain();
        // one full lap of the free list with t order checked on retirement
        target = accepted_total + free_regs;
        guard  = 0;
        while (accepted_total < target) begin
            step(1'b1, 1'b0, 1'b1);
            guard++;
            if (guard > 1000) begin
                timeout_fail("free list lap did not finish");
            end
        end
        drain();
        $display(">>> PASS");
        $finish;
    end

endmodule
